// ==== gfx_pkg.sv ====
`default_nettype none

package gfx_pkg;

	localparam int insn_bits_in_lane = 2; // insn address to lane address shift.
	localparam int insns_in_lane = 1 << insn_bits_in_lane;

	typedef logic [15:0] insn_word;
	typedef logic [31:0] vram_word; // two instructions.
	typedef logic [23:0] vram_addr;
	typedef logic [24:0] vram_insn_addr;
	typedef logic [22:0] vram_lane_addr; // two words per lane.

	typedef logic [insns_in_lane * $bits(insn_word) - 1:0] lane_word; // slot 0 low.
	typedef logic [insns_in_lane - 1:0] lane_mask;

	// upper bits count full blocks, low bits are the tail.
	typedef logic [15:0] cmd_word;

	typedef struct packed {
		lane_word data;
		lane_mask mask;
	} lane_entry;

endpackage

`default_nettype wire

// ==== gfx_sp_widener.sv ====
`timescale 1ns/1ns
`default_nettype none

module gfx_sp_widener (
	input  logic                   clk,
	input  logic                   rst_n,

	input  logic                   lane_read,
	input  gfx_pkg::vram_lane_addr lane_address,
	output gfx_pkg::lane_word      lane_readdata,
	output logic                   lane_waitrequest,
	output logic                   lane_readdatavalid,

	output logic                   batch_read,
	output gfx_pkg::vram_addr      batch_address,
	input  gfx_pkg::vram_word      batch_readdata,
	input  logic                   batch_waitrequest,
	input  logic                   batch_readdatavalid
);

	logic              req_half;
	logic              ret_half;
	gfx_pkg::vram_word ret_low;

	assign batch_read = lane_read;
	assign batch_address = {lane_address, req_half}; // even word first.

	// the lane is accepted only together with its odd word.
	assign lane_waitrequest = batch_waitrequest || !req_half;

	assign lane_readdatavalid = batch_readdatavalid && ret_half;
	assign lane_readdata = {batch_readdata, ret_low};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			req_half <= 1'b0;
			ret_half <= 1'b0;
		end else begin
			if (batch_read && !batch_waitrequest)
				req_half <= !req_half;

			if (batch_readdatavalid)
				ret_half <= !ret_half; // returns keep request order.
		end
	end

	always_ff @(posedge clk) begin
		if (batch_readdatavalid && !ret_half)
			ret_low <= batch_readdata;
	end

endmodule

`default_nettype wire

// ==== gfx_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module gfx_fifo #(
	parameter int width = $bits(gfx_pkg::lane_entry),
	parameter int depth = 8
) (
	input  logic               clk,
	input  logic               rst_n,

	input  gfx_pkg::lane_entry in,
	input  logic               in_valid,
	output logic               in_ready,

	output gfx_pkg::lane_entry out,
	output logic               out_valid,
	input  logic               out_ready
);

	localparam int ptr_bits = $clog2(depth);
	localparam int count_bits = $clog2(depth + 1);

	logic [width - 1:0]    mem [depth];
	logic [ptr_bits - 1:0] rd_ptr;
	logic [ptr_bits - 1:0] wr_ptr;
	logic [count_bits - 1:0] count;
	logic                  push;
	logic                  pop;

	assign in_ready = count != count_bits'(depth);
	assign out_valid = count != '0;
	assign out = mem[rd_ptr]; // head is visible without a read strobe.

	assign push = in_valid && in_ready;
	assign pop = out_valid && out_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == ptr_bits'(depth - 1)) ? '0 : wr_ptr + 1'b1;

			if (pop)
				rd_ptr <= (rd_ptr == ptr_bits'(depth - 1)) ? '0 : rd_ptr + 1'b1;

			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= in;
	end

endmodule

`default_nettype wire

// ==== gfx_fifo_overflow.sv ====
`timescale 1ns/1ns
`default_nettype none

module gfx_fifo_overflow #(
	parameter int depth = 8
) (
	input  logic clk,
	input  logic rst_n,

	input  logic down,
	input  logic up,
	output logic down_safe
);

	localparam int count_bits = $clog2(depth + 1);

	// lanes in flight plus lanes waiting in the fifo.
	logic [count_bits - 1:0] committed;

	// two below depth, so a read issued beside an accepted one still fits.
	assign down_safe = committed < count_bits'(depth - 1);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			committed <= '0;
		end else begin
			case ({down, up})
				2'b10: committed <= committed + 1'b1;
				2'b01: committed <= committed - 1'b1;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== gfx_sp_batch.sv ====
`timescale 1ns/1ns
`default_nettype none

module gfx_sp_batch #(
	parameter int fifo_depth = 8
) (
	input  logic                   clk,
	input  logic                   rst_n,

	output gfx_pkg::vram_addr      batch_address,
	output logic                   batch_read,
	input  gfx_pkg::vram_word      batch_readdata,
	input  logic                   batch_waitrequest,
	input  logic                   batch_readdatavalid,

	input  logic                   batch_start,
	input  gfx_pkg::vram_insn_addr batch_base,
	input  gfx_pkg::cmd_word       batch_length,
	output logic                   batch_busy,

	output gfx_pkg::lane_entry     lane,
	output logic                   lane_valid,
	input  logic                   lane_ready
);

	localparam int tail_bits = gfx_pkg::insn_bits_in_lane;
	localparam int block_bits = $bits(gfx_pkg::cmd_word) - tail_bits;

	typedef enum logic {
		idle,
		stream
	} state_t;

	state_t                 state;
	logic                   lane_read;
	logic                   lane_waitrequest;
	logic                   lane_readdatavalid;
	logic                   lane_accept;
	logic                   down_safe;
	gfx_pkg::lane_word      lane_readdata;
	gfx_pkg::vram_lane_addr lane_address;
	gfx_pkg::lane_entry     fifo_in;
	logic [block_bits - 1:0] fetch_block_count;
	logic [block_bits - 1:0] read_block_count;
	logic [tail_bits - 1:0] read_tail;

	// a start may arrive while the previous batch still has returns in flight.
	logic                   read_active;
	logic                   stash_valid;
	gfx_pkg::cmd_word       stash_length;
	logic                   start_accept;
	logic                   read_last;
	logic                   load_start;
	logic                   load_stash;

	gfx_sp_widener i_widener (.*);

	gfx_fifo #(
		.width($bits(gfx_pkg::lane_entry)),
		.depth(fifo_depth)
	) i_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.in(fifo_in),
		.in_valid(lane_readdatavalid),
		.in_ready(),
		.out(lane),
		.out_valid(lane_valid),
		.out_ready(lane_ready)
	);

	gfx_fifo_overflow #(
		.depth(fifo_depth)
	) i_overflow (
		.clk(clk),
		.rst_n(rst_n),
		.down(lane_accept),
		.up(lane_valid && lane_ready),
		.down_safe(down_safe)
	);

	assign lane_accept = lane_read && !lane_waitrequest;
	assign batch_busy = state == stream || stash_valid;

	assign start_accept = batch_start && state == idle && !stash_valid;
	assign read_last = read_active && lane_readdatavalid && read_block_count == '0;
	assign load_start = start_accept && (!read_active || read_last);
	assign load_stash = read_last && stash_valid;

	assign fifo_in.data = lane_readdata;

	always_comb begin
		fifo_in.mask = gfx_pkg::lane_mask'((1 << read_tail) - 1); // tail lane.
		if (read_block_count != '0)
			fifo_in.mask = '1;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= idle;
			lane_read <= 1'b0;
			read_active <= 1'b0;
			stash_valid <= 1'b0;
		end else begin
			case (state)
				idle: begin
					if (start_accept) begin
						state <= stream;
						lane_read <= down_safe;
					end
				end
				stream: begin
					if (!lane_read || !lane_waitrequest)
						lane_read <= down_safe;

					if (lane_accept && fetch_block_count == '0) begin
						state <= idle;
						lane_read <= 1'b0;
					end
				end
				default: state <= idle;
			endcase

			if (load_start || load_stash)
				read_active <= 1'b1;
			else if (read_last)
				read_active <= 1'b0;

			if (start_accept && !load_start)
				stash_valid <= 1'b1;
			else if (load_stash)
				stash_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (start_accept) begin
			fetch_block_count <= batch_length[tail_bits +: block_bits];
			lane_address <= batch_base[gfx_pkg::insn_bits_in_lane +:
				$bits(gfx_pkg::vram_lane_addr)]; // rounded down to a lane.
			stash_length <= batch_length;
		end else if (lane_accept) begin
			fetch_block_count <= fetch_block_count - 1'b1;
			lane_address <= lane_address + 1'b1;
		end

		if (load_start) begin
			read_block_count <= batch_length[tail_bits +: block_bits];
			read_tail <= batch_length[tail_bits - 1:0];
		end else if (load_stash) begin
			read_block_count <= stash_length[tail_bits +: block_bits];
			read_tail <= stash_length[tail_bits - 1:0];
		end else if (lane_readdatavalid) begin
			read_block_count <= read_block_count - 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== gfx_sp_issue.sv ====
`timescale 1ns/1ns
`default_nettype none

module gfx_sp_issue (
	input  logic               clk,
	input  logic               rst_n,

	input  gfx_pkg::lane_entry lane,
	input  logic               lane_valid,
	output logic               lane_ready,

	output gfx_pkg::insn_word  insn,
	output logic               insn_valid,
	input  logic               insn_ready
);

	gfx_pkg::lane_word                        cur_data;
	gfx_pkg::lane_mask                        rem_mask;
	logic [gfx_pkg::insn_bits_in_lane - 1:0] sel;
	logic                                     fire;
	logic                                     last_slot;

	always_comb begin
		sel = '0;
		for (int i = gfx_pkg::insns_in_lane - 1; i >= 0; i--) begin
			if (rem_mask[i])
				sel = i[gfx_pkg::insn_bits_in_lane - 1:0]; // lowest set slot wins.
		end
	end

	assign insn = cur_data[sel * $bits(gfx_pkg::insn_word) +: $bits(gfx_pkg::insn_word)];
	assign insn_valid = rem_mask != '0;
	assign fire = insn_valid && insn_ready;
	assign last_slot = (rem_mask & (rem_mask - 1'b1)) == '0; // one bit left.

	// empty lanes are taken and dropped without output.
	assign lane_ready = !insn_valid || (insn_ready && last_slot);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rem_mask <= '0;
		end else begin
			if (lane_valid && lane_ready)
				rem_mask <= lane.mask;
			else if (fire)
				rem_mask <= rem_mask & ~(gfx_pkg::lane_mask'(1) << sel);
		end
	end

	always_ff @(posedge clk) begin
		if (lane_valid && lane_ready)
			cur_data <= lane.data;
	end

endmodule

`default_nettype wire

// ==== gfx_sp_front.sv ====
`timescale 1ns/1ns
`default_nettype none

module gfx_sp_front #(
	parameter int fifo_depth = 8
) (
	input  logic                   clk,
	input  logic                   rst_n,

	output gfx_pkg::vram_addr      batch_address,
	output logic                   batch_read,
	input  logic                   batch_waitrequest,
	input  logic                   batch_readdatavalid,
	input  gfx_pkg::vram_word      batch_readdata,

	input  logic                   batch_start,
	input  gfx_pkg::vram_insn_addr batch_base,
	input  gfx_pkg::cmd_word       batch_length,
	output logic                   batch_busy,

	output gfx_pkg::insn_word      insn,
	output logic                   insn_valid,
	input  logic                   insn_ready
);

	gfx_pkg::lane_entry lane;
	logic               lane_valid;
	logic               lane_ready;

	gfx_sp_batch #(
		.fifo_depth(fifo_depth)
	) i_batch (
		.clk(clk),
		.rst_n(rst_n),
		.batch_address(batch_address),
		.batch_read(batch_read),
		.batch_readdata(batch_readdata),
		.batch_waitrequest(batch_waitrequest),
		.batch_readdatavalid(batch_readdatavalid),
		.batch_start(batch_start),
		.batch_base(batch_base),
		.batch_length(batch_length),
		.batch_busy(batch_busy),
		.lane(lane),
		.lane_valid(lane_valid),
		.lane_ready(lane_ready)
	);

	gfx_sp_issue i_issue (
		.clk(clk),
		.rst_n(rst_n),
		.lane(lane),
		.lane_valid(lane_valid),
		.lane_ready(lane_ready),
		.insn(insn),
		.insn_valid(insn_valid),
		.insn_ready(insn_ready)
	);

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
	parameter int period = 4,
	parameter int reset_cycles = 2
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = !clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		#1 rst_n = 1'b1; // release off the edge.
	end

endmodule

`default_nettype wire

// ==== gfx_sp_front_chk.sv ====
`timescale 1ns/1ns
`default_nettype none

module gfx_sp_front_chk (
	input logic               clk,
	input logic               rst_n,
	input logic               in_valid,
	input logic               in_ready,
	input gfx_pkg::lane_entry out,
	input logic               out_valid,
	input logic               out_ready
);

	int unsigned fail_count = 0; // summed into the testbench error count.

	a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) in_valid |-> in_ready)
		else begin
			$error("fifo push while full");
			fail_count++;
		end

	a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out))
		else begin
			$error("fifo head changed while stalled");
			fail_count++;
		end

	a_reset_empty: assert property (@(posedge clk) !rst_n |-> !out_valid)
		else begin
			$error("fifo out_valid high in reset");
			fail_count++;
		end

endmodule

bind gfx_fifo gfx_sp_front_chk i_chk (.clk(clk), .rst_n(rst_n), .in_valid(in_valid),
	.in_ready(in_ready), .out(out), .out_valid(out_valid), .out_ready(out_ready));

`default_nettype wire

// ==== gfx_sp_front_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module gfx_sp_front_tb;

	logic clk, rst_n, batch_read, batch_waitrequest, batch_readdatavalid;
	logic batch_start, batch_busy, insn_valid, insn_ready;
	gfx_pkg::vram_addr      batch_address;
	gfx_pkg::vram_word      batch_readdata;
	gfx_pkg::vram_insn_addr batch_base;
	gfx_pkg::cmd_word       batch_length;
	gfx_pkg::insn_word      insn;

	string       row_name [16];
	logic [24:0] row_base [16];
	int          row_len [16], row_wait [16], row_ready [16], row_left [16], row_err [16];
	bit          row_drain [16];
	int          rows = 0, tests_run = 0, tests_failed = 0, errors = 0, reset_fails = 0;
	int          cur_wait = 0, cur_ready = 100, limit = 200, total = 0, watch_cycles = 0;
	gfx_pkg::insn_word exp_q [$];
	int          exp_row [$];
	gfx_pkg::vram_word data_q [$];
	int          due_q [$];
	int          cycle = 0, last_due = 0;

	tb_clk_gen i_clk_gen (.clk(clk), .rst_n(rst_n));

	gfx_sp_front #(.fifo_depth(8)) i_dut (.*);

	function automatic gfx_pkg::insn_word insn_at(input logic [24:0] a);
		return a[15:0] ^ 16'h5a3c;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual, inout int fails);
		if (expected !== actual) begin
			$display("FAIL %s: expected %h, actual %h", name, expected, actual);
			fails++;
			errors++;
		end
	endtask

	task automatic add_row(input string name, input logic [24:0] base, input int len,
		input int wait_pct, input int ready_pct, input bit drain);
		row_name[rows] = name;
		row_base[rows] = base;
		row_len[rows] = len;
		row_wait[rows] = wait_pct;
		row_ready[rows] = ready_pct;
		row_drain[rows] = drain;
		row_err[rows] = 0;
		total += len;
		rows++;
	endtask

	task automatic report_row(input int r);
		tests_run++;
		if (row_err[r] != 0)
			tests_failed++;
		$display("test %s: %0d instructions, %0d mismatches", row_name[r], row_len[r], row_err[r]);
	endtask

	task automatic start_row(input int r);
		logic [24:0] first;
		first = row_base[r] & ~25'd3; // delivery starts at the lane boundary.
		cur_wait = row_wait[r];
		cur_ready = row_ready[r];
		batch_base = row_base[r];
		batch_length = gfx_pkg::cmd_word'(row_len[r]);
		batch_start = 1'b1;
		row_left[r] = row_len[r];
		for (int k = 0; k < row_len[r]; k++) begin
			exp_q.push_back(insn_at(first + 25'(k)));
			exp_row.push_back(r);
		end
		if (row_len[r] == 0)
			report_row(r);
	endtask

	// word-wide video memory with random stalls and in-order returns.
	always @(posedge clk) begin : vram_model
		int due;
		cycle++;
		if (batch_readdatavalid) begin
			void'(data_q.pop_front());
			void'(due_q.pop_front());
		end
		if (rst_n && batch_read && !batch_waitrequest) begin
			due = cycle + $urandom_range(4, 1);
			if (due <= last_due)
				due = last_due + 1;
			last_due = due;
			due_q.push_back(due);
			data_q.push_back({insn_at({batch_address, 1'b1}), insn_at({batch_address, 1'b0})});
		end
		#1;
		batch_waitrequest = $urandom_range(99) < cur_wait;
		batch_readdatavalid = due_q.size() != 0 && due_q[0] <= cycle;
		batch_readdata = batch_readdatavalid ? data_q[0] : '0;
	end

	always @(posedge clk) begin : insn_sink
		int r;
		if (rst_n && insn_valid && insn_ready) begin
			if (exp_q.size() == 0) begin
				$display("unexpected instruction %h with no batch pending", insn);
				errors++;
			end else begin
				r = exp_row.pop_front();
				check_value(row_name[r], exp_q.pop_front(), insn, row_err[r]);
				row_left[r]--;
				if (row_left[r] == 0)
					report_row(r);
			end
		end
		#1;
		if (cur_ready >= 100)
			insn_ready = 1'b1;
		else if ($urandom_range(9) == 0)
			insn_ready = $urandom_range(99) < cur_ready; // bursty stalls.
	end

	always @(posedge clk) begin : watchdog
		watch_cycles++;
		if (watch_cycles >= limit) begin
			$display("timeout after %0d cycles with %0d instructions outstanding",
				watch_cycles, exp_q.size());
			$display("TESTS FAILED");
			$finish;
		end
	end

	initial begin
		void'($urandom(32'hc42b));
		batch_start = 1'b0;
		batch_base = '0;
		batch_length = '0;
		batch_waitrequest = 1'b0;
		batch_readdatavalid = 1'b0;
		batch_readdata = '0;
		insn_ready = 1'b1;
		add_row("aligned_4", 25'h100, 4, 0, 100, 1);
		add_row("aligned_16", 25'h200, 16, 20, 80, 1);
		add_row("tail_1", 25'h300, 1, 25, 90, 1);
		add_row("tail_2", 25'h304, 2, 25, 90, 1);
		add_row("tail_3", 25'h308, 3, 25, 90, 1);
		add_row("tail_5", 25'h310, 5, 25, 90, 1);
		add_row("tail_0", 25'h320, 0, 25, 90, 1);
		add_row("unaligned", 25'h403, 7, 10, 100, 1);
		add_row("backpressure_64", 25'h1000, 64, 40, 15, 1);
		add_row("chain_a", 25'h2000, 9, 30, 70, 1);
		add_row("chain_b", 25'h2101, 6, 30, 70, 0);
		add_row("chain_c", 25'h2200, 12, 30, 70, 0);
		limit = 20 * total + 200;
		while (!rst_n)
			@(posedge clk);
		repeat (8) begin
			@(posedge clk);
			check_value("reset_read", 0, batch_read, reset_fails);
			check_value("reset_busy", 0, batch_busy, reset_fails);
			check_value("reset_insn_valid", 0, insn_valid, reset_fails);
		end
		tests_run++;
		if (reset_fails != 0)
			tests_failed++;
		$display("test reset: %0d mismatches", reset_fails);
		for (int r = 0; r < rows; r++) begin
			if (row_drain[r])
				while (exp_q.size() != 0)
					@(posedge clk);
			do @(posedge clk); while (batch_busy);
			#1;
			start_row(r);
			@(posedge clk);
			#1;
			batch_start = 1'b0;
		end
		while (exp_q.size() != 0)
			@(posedge clk);
		repeat (40) @(posedge clk); // catch stray output.
		if (i_dut.i_batch.i_fifo.i_chk.fail_count != 0) begin
			$display("fifo checker saw %0d assertion failures",
				i_dut.i_batch.i_fifo.i_chk.fail_count);
			errors += i_dut.i_batch.i_fifo.i_chk.fail_count;
		end
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
gfx_pkg.sv
gfx_sp_widener.sv
gfx_fifo.sv
gfx_fifo_overflow.sv
gfx_sp_batch.sv
gfx_sp_issue.sv
gfx_sp_front.sv
tb_clk_gen.sv
gfx_sp_front_chk.sv
gfx_sp_front_tb.sv

// ==== Bender.yml ====
package:
  name: gfx_sp_front

sources:
  - gfx_pkg.sv
  - gfx_sp_widener.sv
  - gfx_fifo.sv
  - gfx_fifo_overflow.sv
  - gfx_sp_batch.sv
  - gfx_sp_issue.sv
  - gfx_sp_front.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - gfx_sp_front_chk.sv
      - gfx_sp_front_tb.sv
